// File: source/rvvi_bridge_pkg.sv
// Shared types and constants for the RVVI trace bridge
// Retirement, CSR and data-bus trace structs
// Privilege, CSR index and halt FSM enums
// CSR address table, NMI causes and interrupt mask

package rvvi_bridge_pkg;

   ////////////////////////////////////////
   // Widths and counts
   ////////////////////////////////////////

   localparam int XLEN    = 32;
   localparam int NUM_CSR = 8;

   // Privilege mode as seen on the trace
   typedef enum logic [1:0] {
      priv_user    = 2'b00,
      priv_machine = 2'b11
   } priv_mode_e;

   ////////////////////////////////////////
   // Trace records
   ////////////////////////////////////////

   // Raw retirement trace from the core
   typedef struct packed {
      logic             valid;
      logic [31:0]      order;
      logic [31:0]      insn;
      logic             trap;
      logic             intr;
      priv_mode_e       mode;
      logic [XLEN-1:0]  pc_rdata;
      logic [XLEN-1:0]  pc_wdata;
      logic [4:0]       rd_addr;
      logic [XLEN-1:0]  rd_wdata;
   } retire_trace_t;

   // Registered record, one-hot GPR write-back mask appended
   typedef struct packed {
      logic             valid;
      logic [31:0]      order;
      logic [31:0]      insn;
      logic             trap;
      logic             intr;
      priv_mode_e       mode;
      logic [XLEN-1:0]  pc_rdata;
      logic [XLEN-1:0]  pc_wdata;
      logic [4:0]       rd_addr;
      logic [XLEN-1:0]  rd_wdata;
      logic [31:0]      x_wb;
   } retire_rec_t;

   // One CSR access, read and write halves with their masks
   typedef struct packed {
      logic             valid;
      logic [11:0]      addr;
      logic [XLEN-1:0]  rdata;
      logic [XLEN-1:0]  rmask;
      logic [XLEN-1:0]  wdata;
      logic [XLEN-1:0]  wmask;
   } csr_trace_t;

   // Data bus strobes
   typedef struct packed {
      logic req;
      logic we;
      logic rvalid;
      logic err;
   } mem_trace_t;

   ////////////////////////////////////////
   // CSR set
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      csr_mstatus  = 3'd0,
      csr_mie      = 3'd1,
      csr_mtvec    = 3'd2,
      csr_mscratch = 3'd3,
      csr_mepc     = 3'd4,
      csr_mcause   = 3'd5,
      csr_mtval    = 3'd6,
      csr_mip      = 3'd7
   } csr_idx_e;

   // Indexed by csr_idx_e value
   localparam logic [11:0] CSR_ADDR [0:NUM_CSR-1] = '{
      12'h300, 12'h304, 12'h305, 12'h340,
      12'h341, 12'h342, 12'h343, 12'h344
   };

   // NMI causes for load and store bus errors
   localparam logic [31:0] NMI_CAUSE_LOAD  = 32'd1024;
   localparam logic [31:0] NMI_CAUSE_STORE = 32'd1025;

   // MSI, MTI, MEI and the 16 local interrupts
   localparam logic [31:0] IRQ_MASK = 32'hFFFF_0888;

   // Debug halt request hold FSM
   typedef enum logic [1:0] {
      halt_idle     = 2'd0,
      halt_held     = 2'd1,
      halt_hold_off = 2'd2
   } halt_state_e;

endpackage

// File: source/bridge_ctrl.sv
// Retirement record register with one-hot GPR write-back mask
// Shared retire strobe
// Debug halt request hold FSM

`timescale 1ns/1ps

module bridge_ctrl #(
   parameter int HALT_HOLD = 5
) (
   input  logic                           rvvi,
   input  logic                           rst_n_i,
   input  rvvi_bridge_pkg::retire_trace_t retire_i,
   input  logic                           debug_req_i,
   output rvvi_bridge_pkg::retire_rec_t   retire_rec_o,
   output logic                           retire_o,
   output logic                           haltreq_o
);

   // Counter wide enough for HALT_HOLD itself
   localparam int CNT_W = $clog2(HALT_HOLD + 1);

   rvvi_bridge_pkg::retire_rec_t rec_d;
   rvvi_bridge_pkg::retire_rec_t rec_q;

   rvvi_bridge_pkg::halt_state_e state_d;
   rvvi_bridge_pkg::halt_state_e state_q;
   logic [CNT_W-1:0]             cnt_d;
   logic [CNT_W-1:0]             cnt_q;

   ////////////////////////////////////////
   // Retirement record
   ////////////////////////////////////////

   always_comb begin
      rec_d.valid    = retire_i.valid;
      rec_d.order    = retire_i.order;
      rec_d.insn     = retire_i.insn;
      rec_d.trap     = retire_i.trap;
      rec_d.intr     = retire_i.intr;
      rec_d.mode     = retire_i.mode;
      rec_d.pc_rdata = retire_i.pc_rdata;
      rec_d.pc_wdata = retire_i.pc_wdata;
      rec_d.rd_addr  = retire_i.rd_addr;
      rec_d.rd_wdata = retire_i.rd_wdata;
      // x0 is never written back
      rec_d.x_wb     = (retire_i.rd_addr == 5'd0) ? 32'd0 : (32'd1 << retire_i.rd_addr);
   end

   // Only the valid bit is cleared, the rest is payload
   always_ff @(posedge rvvi) begin
      rec_q <= rec_d;
      if (!rst_n_i) begin
         rec_q.valid <= 1'b0;
      end
   end

   assign retire_rec_o = rec_q;
   // One-cycle strobe per retired instruction
   assign retire_o     = rec_q.valid;

   ////////////////////////////////////////
   // Halt hold FSM
   ////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      if (debug_req_i) begin
         // New or repeated request restarts the hold
         state_d = rvvi_bridge_pkg::halt_held;
      end else begin
         case (state_q)
            rvvi_bridge_pkg::halt_held: begin
               if (HALT_HOLD == 0) begin
                  state_d = rvvi_bridge_pkg::halt_idle;
               end else begin
                  state_d = rvvi_bridge_pkg::halt_hold_off;
                  // First hold cycle starts now
                  cnt_d   = CNT_W'(HALT_HOLD - 1);
               end
            end
            rvvi_bridge_pkg::halt_hold_off: begin
               if (cnt_q == '0) begin
                  state_d = rvvi_bridge_pkg::halt_idle;
               end else begin
                  cnt_d = cnt_q - 1'b1;
               end
            end
            default: begin
               state_d = rvvi_bridge_pkg::halt_idle;
            end
         endcase
      end
   end

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         state_q <= rvvi_bridge_pkg::halt_idle;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
      end
   end

   // High in held and through the whole hold-off window
   assign haltreq_o = (state_q != rvvi_bridge_pkg::halt_idle);

endmodule

// File: source/csr_shadow.sv
// Shadow copies of the eight machine CSRs
// Address decode against the CSR table
// Read then write merge under masks, write-back flags

`timescale 1ns/1ps

module csr_shadow (
   input  logic                                rvvi,
   input  logic                                rst_n_i,
   input  rvvi_bridge_pkg::csr_trace_t         csr_i,
   input  logic                                retire_i,
   output logic [rvvi_bridge_pkg::NUM_CSR-1:0]
                [rvvi_bridge_pkg::XLEN-1:0]    csr_val_o,
   output logic [rvvi_bridge_pkg::NUM_CSR-1:0] csr_wb_o
);

   logic [rvvi_bridge_pkg::NUM_CSR-1:0][rvvi_bridge_pkg::XLEN-1:0] shadow_q;
   logic [rvvi_bridge_pkg::NUM_CSR-1:0]                            wb_q;

   logic                              hit;
   rvvi_bridge_pkg::csr_idx_e         sel;
   logic [rvvi_bridge_pkg::XLEN-1:0]  rd_merged;
   logic [rvvi_bridge_pkg::XLEN-1:0]  new_val;

   // Replace the masked bits of old_val with data
   function automatic logic [rvvi_bridge_pkg::XLEN-1:0] merge_masked(
      input logic [rvvi_bridge_pkg::XLEN-1:0] old_val,
      input logic [rvvi_bridge_pkg::XLEN-1:0] data,
      input logic [rvvi_bridge_pkg::XLEN-1:0] mask
   );
      return (old_val & ~mask) | (data & mask);
   endfunction

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////

   always_comb begin
      hit = 1'b0;
      sel = rvvi_bridge_pkg::csr_mstatus;
      for (int i = 0; i < rvvi_bridge_pkg::NUM_CSR; i++) begin
         if (csr_i.addr == rvvi_bridge_pkg::CSR_ADDR[i]) begin
            // Unknown addresses never raise hit
            hit = csr_i.valid;
            sel = rvvi_bridge_pkg::csr_idx_e'(i);
         end
      end
   end

   // Read data first, write data on top
   assign rd_merged = merge_masked(shadow_q[sel], csr_i.rdata, csr_i.rmask);
   assign new_val   = merge_masked(rd_merged, csr_i.wdata, csr_i.wmask);

   ////////////////////////////////////////
   // Shadow registers and flags
   ////////////////////////////////////////

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         shadow_q <= '0;
      end else if (hit) begin
         shadow_q[sel] <= new_val;
      end
   end

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         wb_q <= '0;
      end else begin
         for (int i = 0; i < rvvi_bridge_pkg::NUM_CSR; i++) begin
            // Access beats the retire clear
            if (hit && (sel == rvvi_bridge_pkg::csr_idx_e'(i))) begin
               wb_q[i] <= 1'b1;
            end else if (retire_i) begin
               wb_q[i] <= 1'b0;
            end
         end
      end
   end

   assign csr_val_o = shadow_q;
   assign csr_wb_o  = wb_q;

endmodule

// File: source/ldst_cause_fifo.sv
// Queue of load/store direction per outstanding data request
// Cause register from the popped entry
// Registered NMI level on bus error

`timescale 1ns/1ps

module ldst_cause_fifo #(
   parameter int LDST_DEPTH = 4
) (
   input  logic                        rvvi,
   input  logic                        rst_n_i,
   input  rvvi_bridge_pkg::mem_trace_t mem_i,
   input  logic                        retire_i,
   output logic                        nmi_o,
   output logic [31:0]                 nmi_cause_o
);

   localparam int PTR_W = (LDST_DEPTH > 1) ? $clog2(LDST_DEPTH) : 1;
   localparam int CNT_W = $clog2(LDST_DEPTH + 1);

   // Direction bits, 1 for store
   logic [LDST_DEPTH-1:0] dir_q;
   logic [PTR_W-1:0]      wr_ptr_q;
   logic [PTR_W-1:0]      rd_ptr_q;
   logic [CNT_W-1:0]      count_q;

   logic                  push;
   logic                  pop;
   logic [31:0]           cause_q;
   logic                  nmi_q;

   // Full queue drops the push, empty queue ignores the pop
   assign push = mem_i.req && (count_q != CNT_W'(LDST_DEPTH));
   assign pop  = retire_i && (count_q != '0);

   ////////////////////////////////////////
   // Queue storage and pointers
   ////////////////////////////////////////

   always_ff @(posedge rvvi) begin
      if (push) begin
         dir_q[wr_ptr_q] <= mem_i.we;
      end
   end

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(LDST_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(LDST_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         // Net occupancy change
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   ////////////////////////////////////////
   // Cause and NMI level
   ////////////////////////////////////////

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         cause_q <= rvvi_bridge_pkg::NMI_CAUSE_LOAD;
         nmi_q   <= 1'b0;
      end else begin
         if (pop) begin
            cause_q <= dir_q[rd_ptr_q] ? rvvi_bridge_pkg::NMI_CAUSE_STORE
                                       : rvvi_bridge_pkg::NMI_CAUSE_LOAD;
         end
         // Error response on the data bus
         nmi_q <= mem_i.err && mem_i.rvalid;
      end
   end

   assign nmi_o       = nmi_q;
   assign nmi_cause_o = cause_q;

endmodule

// File: source/irq_change_det.sv
// Interrupt vector filter and register
// One-cycle pulse when the filtered vector changes

`timescale 1ns/1ps

module irq_change_det (
   input  logic        rvvi,
   input  logic        rst_n_i,
   input  logic [31:0] irq_i,
   output logic [31:0] irq_o,
   output logic        irq_chg_o
);

   logic [31:0] irq_masked;
   logic [31:0] irq_q;
   logic        chg_q;

   // Bits outside the mask never reach the reference
   assign irq_masked = irq_i & rvvi_bridge_pkg::IRQ_MASK;

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         irq_q <= '0;
         chg_q <= 1'b0;
      end else begin
         irq_q <= irq_masked;
         // Compare against the value currently shown
         chg_q <= (irq_masked != irq_q);
      end
   end

   assign irq_o     = irq_q;
   assign irq_chg_o = chg_q;

endmodule

// File: source/rvvi_bridge_top.sv
// Top level of the RVVI trace bridge
// Control block plus CSR shadow, NMI cause queue and IRQ filter

`timescale 1ns/1ps

module rvvi_bridge_top #(
   parameter int HALT_HOLD  = 5,
   parameter int LDST_DEPTH = 4
) (
   input  logic                                rvvi,
   input  logic                                rst_n_i,
   // Core side trace
   input  rvvi_bridge_pkg::retire_trace_t      retire_i,
   input  rvvi_bridge_pkg::csr_trace_t         csr_i,
   input  rvvi_bridge_pkg::mem_trace_t         mem_i,
   input  logic                                debug_req_i,
   input  logic [31:0]                         irq_i,
   // Reference side view
   output rvvi_bridge_pkg::retire_rec_t        retire_rec_o,
   output logic [rvvi_bridge_pkg::NUM_CSR-1:0]
                [rvvi_bridge_pkg::XLEN-1:0]    csr_val_o,
   output logic [rvvi_bridge_pkg::NUM_CSR-1:0] csr_wb_o,
   output logic                                haltreq_o,
   output logic                                nmi_o,
   output logic [31:0]                         nmi_cause_o,
   output logic [31:0]                         irq_o,
   output logic                                irq_chg_o
);

   // Registered trace valid, shared by the shadow and the queue
   logic retire_strobe;

   ////////////////////////////////////////
   // Retirement record and halt request
   ////////////////////////////////////////

   bridge_ctrl #(
      .HALT_HOLD (HALT_HOLD)
   ) bridge_ctrl_inst (
      .rvvi         (rvvi),
      .rst_n_i      (rst_n_i),
      .retire_i     (retire_i),
      .debug_req_i  (debug_req_i),
      .retire_rec_o (retire_rec_o),
      .retire_o     (retire_strobe),
      .haltreq_o    (haltreq_o)
   );

   ////////////////////////////////////////
   // Datapath blocks
   ////////////////////////////////////////

   csr_shadow csr_shadow_inst (
      .rvvi      (rvvi),
      .rst_n_i   (rst_n_i),
      .csr_i     (csr_i),
      .retire_i  (retire_strobe),
      .csr_val_o (csr_val_o),
      .csr_wb_o  (csr_wb_o)
   );

   // Load/store direction per request, popped on retirement
   ldst_cause_fifo #(
      .LDST_DEPTH (LDST_DEPTH)
   ) ldst_cause_fifo_inst (
      .rvvi        (rvvi),
      .rst_n_i     (rst_n_i),
      .mem_i       (mem_i),
      .retire_i    (retire_strobe),
      .nmi_o       (nmi_o),
      .nmi_cause_o (nmi_cause_o)
   );

   irq_change_det irq_change_det_inst (
      .rvvi      (rvvi),
      .rst_n_i   (rst_n_i),
      .irq_i     (irq_i),
      .irq_o     (irq_o),
      .irq_chg_o (irq_chg_o)
   );

endmodule

// File: dv/tb_rvvi_bridge.sv
// Testbench for the RVVI trace bridge
// Reads per-cycle vectors from the stimulus file, drives the DUT and checks outputs
// Reset state check, error counts and cycle timeout

`timescale 1ns/1ps

module tb_rvvi_bridge;

   localparam string STIM_FILE = "dv/rvvi_bridge_stimulus.txt";

   // One line of the stimulus file
   typedef struct packed {
      logic [7:0]  tid;
      logic        rv;
      logic [31:0] order;
      logic [4:0]  rd;
      logic        cv;
      logic [11:0] addr;
      logic [31:0] rdata;
      logic [31:0] rmask;
      logic [31:0] wdata;
      logic [31:0] wmask;
      logic [3:0]  mem;
      logic        dbg;
      logic [31:0] irq;
      logic        e_rv;
      logic [31:0] e_xwb;
      logic [2:0]  e_idx;
      logic [31:0] e_val;
      logic [7:0]  e_wb;
      logic        e_halt;
      logic        e_nmi;
      logic [31:0] e_cause;
      logic [31:0] e_irq;
      logic        e_chg;
   } vec_t;

   logic                                   rvvi;
   logic                                   rst_n_i;
   rvvi_bridge_pkg::retire_trace_t         retire_i;
   rvvi_bridge_pkg::csr_trace_t            csr_i;
   rvvi_bridge_pkg::mem_trace_t            mem_i;
   logic                                   debug_req_i;
   logic [31:0]                            irq_i;
   rvvi_bridge_pkg::retire_rec_t           retire_rec_o;
   logic [rvvi_bridge_pkg::NUM_CSR-1:0]
         [rvvi_bridge_pkg::XLEN-1:0]       csr_val_o;
   logic [rvvi_bridge_pkg::NUM_CSR-1:0]    csr_wb_o;
   logic                                   haltreq_o;
   logic                                   nmi_o;
   logic [31:0]                            nmi_cause_o;
   logic [31:0]                            irq_o;
   logic                                   irq_chg_o;

   vec_t                           vecs[$];
   rvvi_bridge_pkg::retire_trace_t last_trace;
   int                             mismatch_cnt = 0;
   int                             other_cnt    = 0;
   int                             cycle_cnt    = 0;
   int                             cycle_limit  = 0;

   rvvi_bridge_top rvvi_bridge_top_inst (
      .rvvi         (rvvi),
      .rst_n_i      (rst_n_i),
      .retire_i     (retire_i),
      .csr_i        (csr_i),
      .mem_i        (mem_i),
      .debug_req_i  (debug_req_i),
      .irq_i        (irq_i),
      .retire_rec_o (retire_rec_o),
      .csr_val_o    (csr_val_o),
      .csr_wb_o     (csr_wb_o),
      .haltreq_o    (haltreq_o),
      .nmi_o        (nmi_o),
      .nmi_cause_o  (nmi_cause_o),
      .irq_o        (irq_o),
      .irq_chg_o    (irq_chg_o)
   );

   // 8 ns period
   always #4 rvvi = ~rvvi;

   ////////////////////////////////////////
   // Timeout
   ////////////////////////////////////////

   always @(posedge rvvi) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("ERROR: timeout, run did not end within %0d cycles", cycle_limit);
         $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt + 1);
         $display("Finished with errors");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic string test_name(input logic [7:0] tid);
      case (tid)
         8'd1:    return "retire";
         8'd2:    return "csr_shadow";
         8'd3:    return "halt_hold";
         8'd4:    return "nmi_cause";
         8'd5:    return "irq_filter";
         8'd6:    return "reset";
         default: return "unknown";
      endcase
   endfunction

   task automatic report_mismatch(input string test, input string field,
                                  input logic [31:0] exp_val, input logic [31:0] act_val);
      mismatch_cnt++;
      $display("MISMATCH %s %s at %0t: expected %h, actual %h",
               test, field, $time, exp_val, act_val);
   endtask

   // Payload fields are derived from order so the record can be traced back
   task automatic drive_inputs(input vec_t v);
      retire_i          = '0;
      retire_i.valid    = v.rv;
      retire_i.order    = v.order;
      retire_i.insn     = 32'h0000_0013 + v.order;
      retire_i.trap     = v.order[0];
      retire_i.intr     = v.order[1];
      retire_i.mode     = v.order[2] ? rvvi_bridge_pkg::priv_user
                                     : rvvi_bridge_pkg::priv_machine;
      retire_i.pc_rdata = 32'h8000_0000 + (v.order << 2);
      retire_i.pc_wdata = 32'h8000_0004 + (v.order << 2);
      retire_i.rd_addr  = v.rd;
      retire_i.rd_wdata = v.order ^ 32'hA5A5_0000;
      last_trace        = retire_i;
      csr_i.valid       = v.cv;
      csr_i.addr        = v.addr;
      csr_i.rdata       = v.rdata;
      csr_i.rmask       = v.rmask;
      csr_i.wdata       = v.wdata;
      csr_i.wmask       = v.wmask;
      // Nibble order is req, we, rvalid, err
      mem_i             = rvvi_bridge_pkg::mem_trace_t'(v.mem);
      debug_req_i       = v.dbg;
      irq_i             = v.irq;
   endtask

   task automatic check_outputs(input vec_t v);
      string name;
      name = test_name(v.tid);
      if (retire_rec_o.valid !== v.e_rv)
         report_mismatch(name, "rec.valid", 32'(v.e_rv), 32'(retire_rec_o.valid));
      if (retire_rec_o.x_wb !== v.e_xwb)
         report_mismatch(name, "rec.x_wb", v.e_xwb, retire_rec_o.x_wb);
      // Record payload follows the trace of the previous edge
      if (retire_rec_o.order !== last_trace.order)
         report_mismatch(name, "rec.order", last_trace.order, retire_rec_o.order);
      if (retire_rec_o.insn !== last_trace.insn)
         report_mismatch(name, "rec.insn", last_trace.insn, retire_rec_o.insn);
      if (retire_rec_o.trap !== last_trace.trap)
         report_mismatch(name, "rec.trap", 32'(last_trace.trap), 32'(retire_rec_o.trap));
      if (retire_rec_o.intr !== last_trace.intr)
         report_mismatch(name, "rec.intr", 32'(last_trace.intr), 32'(retire_rec_o.intr));
      if (retire_rec_o.mode !== last_trace.mode)
         report_mismatch(name, "rec.mode", 32'(last_trace.mode), 32'(retire_rec_o.mode));
      if (retire_rec_o.pc_rdata !== last_trace.pc_rdata)
         report_mismatch(name, "rec.pc_rdata", last_trace.pc_rdata, retire_rec_o.pc_rdata);
      if (retire_rec_o.pc_wdata !== last_trace.pc_wdata)
         report_mismatch(name, "rec.pc_wdata", last_trace.pc_wdata, retire_rec_o.pc_wdata);
      if (retire_rec_o.rd_addr !== last_trace.rd_addr)
         report_mismatch(name, "rec.rd_addr", 32'(last_trace.rd_addr),
                         32'(retire_rec_o.rd_addr));
      if (retire_rec_o.rd_wdata !== last_trace.rd_wdata)
         report_mismatch(name, "rec.rd_wdata", last_trace.rd_wdata, retire_rec_o.rd_wdata);
      if (csr_val_o[v.e_idx] !== v.e_val)
         report_mismatch(name, "csr_val", v.e_val, csr_val_o[v.e_idx]);
      if (csr_wb_o !== v.e_wb)
         report_mismatch(name, "csr_wb", 32'(v.e_wb), 32'(csr_wb_o));
      if (haltreq_o !== v.e_halt)
         report_mismatch(name, "haltreq", 32'(v.e_halt), 32'(haltreq_o));
      if (nmi_o !== v.e_nmi)
         report_mismatch(name, "nmi", 32'(v.e_nmi), 32'(nmi_o));
      if (nmi_cause_o !== v.e_cause)
         report_mismatch(name, "nmi_cause", v.e_cause, nmi_cause_o);
      if (irq_o !== v.e_irq)
         report_mismatch(name, "irq", v.e_irq, irq_o);
      if (irq_chg_o !== v.e_chg)
         report_mismatch(name, "irq_chg", 32'(v.e_chg), 32'(irq_chg_o));
   endtask

   // Everything quiet, shadows zero, cause back to the load code
   task automatic check_reset_state();
      if (retire_rec_o.valid !== 1'b0)
         report_mismatch("reset", "rec.valid", 32'd0, 32'(retire_rec_o.valid));
      if (csr_wb_o !== '0)
         report_mismatch("reset", "csr_wb", 32'd0, 32'(csr_wb_o));
      for (int k = 0; k < rvvi_bridge_pkg::NUM_CSR; k++) begin
         if (csr_val_o[k] !== 32'd0)
            report_mismatch("reset", "csr_val", 32'd0, csr_val_o[k]);
      end
      if (haltreq_o !== 1'b0)
         report_mismatch("reset", "haltreq", 32'd0, 32'(haltreq_o));
      if (nmi_o !== 1'b0)
         report_mismatch("reset", "nmi", 32'd0, 32'(nmi_o));
      if (irq_chg_o !== 1'b0)
         report_mismatch("reset", "irq_chg", 32'd0, 32'(irq_chg_o));
      if (nmi_cause_o !== 32'd1024)
         report_mismatch("reset", "nmi_cause", 32'd1024, nmi_cause_o);
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      int          fd;
      int          n;
      string       line;
      logic [31:0] f [0:22];
      vec_t        v;

      rvvi        = 1'b0;
      rst_n_i     = 1'b0;
      retire_i    = '0;
      csr_i       = '0;
      mem_i       = '0;
      debug_req_i = 1'b0;
      irq_i       = '0;
      last_trace  = '0;

      // Load all vectors before the clock matters
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("ERROR: cannot open stimulus file %s", STIM_FILE);
         other_cnt++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                           f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                           f[20], f[21], f[22]);
               if (n == 23) begin
                  v.tid     = f[0][7:0];
                  v.rv      = f[1][0];
                  v.order   = f[2];
                  v.rd      = f[3][4:0];
                  v.cv      = f[4][0];
                  v.addr    = f[5][11:0];
                  v.rdata   = f[6];
                  v.rmask   = f[7];
                  v.wdata   = f[8];
                  v.wmask   = f[9];
                  v.mem     = f[10][3:0];
                  v.dbg     = f[11][0];
                  v.irq     = f[12];
                  v.e_rv    = f[13][0];
                  v.e_xwb   = f[14];
                  v.e_idx   = f[15][2:0];
                  v.e_val   = f[16];
                  v.e_wb    = f[17][7:0];
                  v.e_halt  = f[18][0];
                  v.e_nmi   = f[19][0];
                  v.e_cause = f[20];
                  v.e_irq   = f[21];
                  v.e_chg   = f[22][0];
                  vecs.push_back(v);
               end else if (n > 0) begin
                  $display("ERROR: malformed stimulus line with %0d fields", n);
                  other_cnt++;
               end
            end
         end
         $fclose(fd);
      end
      if (vecs.size() == 0) begin
         $display("ERROR: no stimulus vectors were read");
         other_cnt++;
      end
      cycle_limit = 2 * vecs.size() + 20;

      // Reset for 8 cycles
      repeat (8) @(posedge rvvi);
      #1;
      check_reset_state();
      rst_n_i = 1'b1;

      foreach (vecs[i]) begin
         drive_inputs(vecs[i]);
         @(posedge rvvi);
         #1;
         check_outputs(vecs[i]);
      end

      $display("Summary: %0d vectors, %0d mismatches, %0d other errors",
               vecs.size(), mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: dv/rvvi_bridge_stimulus.txt
# tid rv order rd csr_v addr rdata rmask wdata wmask mem(req,we,rvalid,err) dbg irq (hex, tid dec)
# then expected: rv x_wb csr_idx csr_val csr_wb halt nmi cause irq irq_chg
1 1 01 05 0 000 0 0 0 0 0 0 00000000  1 00000020 0 00000000 00 0 0 400 00000000 0
1 1 02 00 0 000 0 0 0 0 0 0 00000000  1 00000000 0 00000000 00 0 0 400 00000000 0
1 1 03 1f 0 000 0 0 0 0 0 0 00000000  1 80000000 0 00000000 00 0 0 400 00000000 0
1 0 04 03 0 000 0 0 0 0 0 0 00000000  0 00000008 0 00000000 00 0 0 400 00000000 0
1 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 0 00000000 00 0 0 400 00000000 0
2 0 00 00 1 300 0000ffff 00ff00ff 12340000 ff000000 0 0 00000000  0 0 0 120000ff 01 0 0 400 0 0
2 0 00 00 1 301 ffffffff ffffffff ffffffff ffffffff 0 0 00000000  0 0 0 120000ff 01 0 0 400 0 0
2 1 08 02 0 000 0 0 0 0 0 0 00000000  1 00000004 0 120000ff 01 0 0 400 00000000 0
2 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 0 120000ff 00 0 0 400 00000000 0
2 1 0a 00 1 341 0 0 80000100 ffffffff 0 0 00000000  1 00000000 4 80000100 10 0 0 400 0 0
2 0 00 00 1 341 0 0 80000200 ffffffff 0 0 00000000  0 00000000 4 80000200 10 0 0 400 0 0
2 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 4 80000200 10 0 0 400 00000000 0
2 1 0c 0a 0 000 0 0 0 0 0 0 00000000  1 00000400 4 80000200 10 0 0 400 00000000 0
2 0 00 00 1 305 0 0 00000001 00000003 0 0 00000000  0 00000000 2 00000001 04 0 0 400 0 0
2 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 4 80000200 04 0 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 1 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 1 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 0 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 1 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 1 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 1 0 400 00000000 0
3 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 2 00000001 04 0 0 400 00000000 0
4 0 00 00 0 000 0 0 0 0 c 0 00000000  0 00000000 2 00000001 04 0 0 400 00000000 0
4 1 23 04 0 000 0 0 0 0 8 0 00000000  1 00000010 2 00000001 04 0 0 400 00000000 0
4 0 00 00 0 000 0 0 0 0 3 0 00000000  0 00000000 0 120000ff 00 0 1 401 00000000 0
4 1 25 00 0 000 0 0 0 0 0 0 00000000  1 00000000 0 120000ff 00 0 0 401 00000000 0
4 0 00 00 0 000 0 0 0 0 f 0 00000000  0 00000000 0 120000ff 00 0 1 400 00000000 0
4 1 27 00 0 000 0 0 0 0 0 0 00000000  1 00000000 0 120000ff 00 0 0 400 00000000 0
4 1 28 00 0 000 0 0 0 0 0 0 00000000  1 00000000 0 120000ff 00 0 0 401 00000000 0
4 0 00 00 0 000 0 0 0 0 3 0 00000000  0 00000000 0 120000ff 00 0 1 401 00000000 0
4 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 0 120000ff 00 0 0 401 00000000 0
5 0 00 00 0 000 0 0 0 0 0 0 00000888  0 00000000 0 120000ff 00 0 0 401 00000888 1
5 0 00 00 0 000 0 0 0 0 0 0 00000888  0 00000000 0 120000ff 00 0 0 401 00000888 0
5 0 00 00 0 000 0 0 0 0 0 0 00000889  0 00000000 0 120000ff 00 0 0 401 00000888 0
5 0 00 00 0 000 0 0 0 0 0 0 0000f889  0 00000000 0 120000ff 00 0 0 401 00000888 0
5 0 00 00 0 000 0 0 0 0 0 0 0001f889  0 00000000 0 120000ff 00 0 0 401 00010888 1
5 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 0 120000ff 00 0 0 401 00000000 1
5 0 00 00 0 000 0 0 0 0 0 0 00000000  0 00000000 0 120000ff 00 0 0 401 00000000 0

// File: verilog.f
source/rvvi_bridge_pkg.sv
source/bridge_ctrl.sv
source/csr_shadow.sv
source/ldst_cause_fifo.sv
source/irq_change_det.sv
source/rvvi_bridge_top.sv
dv/tb_rvvi_bridge.sv

// File: run.sh
#!/bin/sh
# Build and run the RVVI bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
   -f verilog.f --top-module tb_rvvi_bridge
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_rvvi_bridge)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1
